// ==== hw/mips_pkg.sv ====
// mips pipeline shared types
package mips_pkg;

   // basic widths
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [29:0] word_addr_t;
   // bit k enables byte lane k, little-endian
   typedef logic [3:0]  byte_en_t;

   // primary opcodes kept by this core
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDI    = 6'h08,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_SLTIU   = 6'h0b,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SB      = 6'h28,
      OP_SH      = 6'h29,
      OP_SW      = 6'h2b
   } opcode_e;

   // special group function codes
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SLLV    = 6'h04,
      FN_SRLV    = 6'h06,
      FN_SRAV    = 6'h07,
      FN_SYSCALL = 6'h0c,
      FN_ADD     = 6'h20,
      FN_ADDU    = 6'h21,
      FN_SUB     = 6'h22,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a,
      FN_SLTU    = 6'h2b
   } funct_e;

   // alu_add is zero so an all-zero control word is a bubble
   typedef enum logic [4:0] {
      ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
      ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_LUI,
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV
   } alu_op_e;

   typedef enum logic [2:0] {LD_NONE, LD_LB, LD_LBU, LD_LH, LD_LHU, LD_LW} load_op_e;
   typedef enum logic [1:0] {ST_NONE, ST_SB, ST_SH, ST_SW} store_op_e;

   // control carried down the pipe
   typedef struct packed {
      logic      reg_we;
      reg_idx_t  wr_reg;
      alu_op_e   alu_op;
      logic      use_imm;
      load_op_e  load_op;
      store_op_e store_op;
      logic      is_sys;
   } ctrl_t;

   typedef struct packed {
      ctrl_t      ctrl;
      word_t      rs_val;
      word_t      rt_val;
      word_t      imm;
      logic [4:0] shamt;
   } id_ex_t;

   typedef struct packed {
      ctrl_t ctrl;
      // effective address for loads and stores
      word_t alu_result;
      word_t store_val;
   } ex_mem_t;

   typedef struct packed {
      logic     reg_we;
      reg_idx_t wr_reg;
      word_t    wr_data;
      logic     is_sys;
   } mem_wb_t;

endpackage

// ==== hw/mips_regfile.sv ====
// mips register file
module mips_regfile (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs_idx,
   input  mips_pkg::reg_idx_t rt_idx,
   output mips_pkg::word_t    rs_val,
   output mips_pkg::word_t    rt_val,
   input  mips_pkg::mem_wb_t  wb
);
   import mips_pkg::*;

   word_t regs [32];

   // same-cycle write shows up on the read port
   function automatic word_t read_port(reg_idx_t idx, mem_wb_t w);
      if (w.reg_we && (w.wr_reg == idx) && (idx != '0)) begin
         return w.wr_data;
      end
      return regs[idx];
   endfunction

   // r0 is never written so it holds its reset zero
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.reg_we && (wb.wr_reg != '0)) begin
         regs[wb.wr_reg] <= wb.wr_data;
      end
   end

   always_comb begin
      rs_val = read_port(rs_idx, wb);
      rt_val = read_port(rt_idx, wb);
   end

endmodule

// ==== hw/mips_alu.sv ====
// mips integer alu
module mips_alu (
   input  mips_pkg::alu_op_e op,
   input  mips_pkg::word_t   a,
   input  mips_pkg::word_t   b,
   input  logic [4:0]        shamt,
   output mips_pkg::word_t   result
);
   import mips_pkg::*;

   // variable shift count from rs
   logic [4:0] var_sh;

   assign var_sh = a[4:0];

   always_comb begin
      case (op)
         // overflow is not trapped, so signed and unsigned forms match
         ALU_ADD, ALU_ADDU: result = a + b;
         ALU_SUB, ALU_SUBU: result = a - b;
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         ALU_XOR: result = a ^ b;
         ALU_NOR: result = ~(a | b);
         // immediate goes to the upper half
         ALU_LUI: result = {b[15:0], 16'h0000};
         ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
         ALU_SLTU: result = {31'b0, a < b};
         // shifts always act on rt, which is b
         ALU_SLL: result = b << shamt;
         ALU_SRL: result = b >> shamt;
         ALU_SRA: result = $signed(b) >>> shamt;
         ALU_SLLV: result = b << var_sh;
         ALU_SRLV: result = b >> var_sh;
         ALU_SRAV: result = $signed(b) >>> var_sh;
         default: result = a + b;
      endcase
   end

endmodule

// ==== hw/mips_mem_align.sv ====
// load and store lane alignment
module mips_mem_align (
   input  mips_pkg::ex_mem_t  ex_mem,
   input  mips_pkg::word_t    mem_data_out,
   output mips_pkg::word_t    mem_data_in,
   output mips_pkg::byte_en_t mem_write_en,
   output mips_pkg::word_t    load_data
);
   import mips_pkg::*;

   logic [1:0] k;
   logic [4:0] lane_shift;
   word_t      shifted;

   // byte offset inside the word
   assign k          = ex_mem.alu_result[1:0];
   assign lane_shift = {k, 3'b000};
   // addressed byte or half moved down to lane 0
   assign shifted    = mem_data_out >> lane_shift;

   // store side
   always_comb begin
      case (ex_mem.ctrl.store_op)
         ST_SB: begin
            mem_data_in  = {24'h0, ex_mem.store_val[7:0]} << lane_shift;
            mem_write_en = 4'b0001 << k;
         end
         ST_SH: begin
            mem_data_in  = {16'h0, ex_mem.store_val[15:0]} << lane_shift;
            mem_write_en = 4'b0011 << k;
         end
         ST_SW: begin
            mem_data_in  = ex_mem.store_val;
            mem_write_en = 4'b1111;
         end
         default: begin
            mem_data_in  = ex_mem.store_val;
            mem_write_en = 4'b0000;
         end
      endcase
   end

   // load side, extend after the shift
   always_comb begin
      case (ex_mem.ctrl.load_op)
         LD_LB:   load_data = {{24{shifted[7]}}, shifted[7:0]};
         LD_LBU:  load_data = {24'h0, shifted[7:0]};
         LD_LH:   load_data = {{16{shifted[15]}}, shifted[15:0]};
         LD_LHU:  load_data = {16'h0, shifted[15:0]};
         default: load_data = mem_data_out;
      endcase
   end

   // no access may straddle a word, the compiler aligns halves and words
   always_comb begin
      if ((ex_mem.ctrl.store_op == ST_SH) || (ex_mem.ctrl.load_op inside {LD_LH, LD_LHU})) begin
         assert (k[0] == 1'b0);
      end
      if ((ex_mem.ctrl.store_op == ST_SW) || (ex_mem.ctrl.load_op == LD_LW)) begin
         assert (k == 2'b00);
      end
   end

endmodule

// ==== hw/mips_decode.sv ====
// mips decode stage
module mips_decode (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::word_t    inst,
   input  logic               pc_plus4_en,
   output mips_pkg::reg_idx_t rs_idx,
   output mips_pkg::reg_idx_t rt_idx,
   input  mips_pkg::word_t    rs_val,
   input  mips_pkg::word_t    rt_val,
   input  mips_pkg::ctrl_t    ex_ctrl,
   input  mips_pkg::ctrl_t    mem_ctrl,
   output mips_pkg::id_ex_t   id_ex,
   output logic               stall,
   output logic               sys_seen
);
   import mips_pkg::*;

   word_t       inst_q;
   logic        inst_valid;
   logic        sys_issued;
   opcode_e     op;
   funct_e      funct;
   reg_idx_t    rd;
   logic [15:0] imm16;
   logic        zext;
   logic        hazard;
   ctrl_t       dec;

   // true when r is read here and still pending in a later stage
   function automatic logic raw_hit(reg_idx_t r, ctrl_t c);
      return (r != '0) && c.reg_we && (c.wr_reg == r);
   endfunction

   // decode register, loads whenever fetch advances
   always_ff @(posedge clk) begin
      if (pc_plus4_en) begin
         inst_q <= inst;
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         inst_valid <= 1'b0;
         sys_issued <= 1'b0;
      end else begin
         if (pc_plus4_en) begin
            inst_valid <= 1'b1;
         end
         // syscall goes down once, then it only holds fetch
         if (sys_seen && !stall) begin
            sys_issued <= 1'b1;
         end
      end
   end

   // field split
   assign op     = opcode_e'(inst_q[31:26]);
   assign funct  = funct_e'(inst_q[5:0]);
   assign rs_idx = inst_q[25:21];
   assign rt_idx = inst_q[20:16];
   assign rd     = inst_q[15:11];
   assign imm16  = inst_q[15:0];
   // logic immediates are zero extended, the rest sign extended
   assign zext   = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);

   always_comb begin
      // i-type defaults, rt is the destination
      dec         = '0;
      dec.reg_we  = 1'b1;
      dec.wr_reg  = rt_idx;
      dec.use_imm = 1'b1;
      dec.alu_op  = ALU_ADDU;
      case (op)
         OP_SPECIAL: begin
            dec.wr_reg  = rd;
            dec.use_imm = 1'b0;
            case (funct)
               FN_SLL:  dec.alu_op = ALU_SLL;
               FN_SRL:  dec.alu_op = ALU_SRL;
               FN_SRA:  dec.alu_op = ALU_SRA;
               FN_SLLV: dec.alu_op = ALU_SLLV;
               FN_SRLV: dec.alu_op = ALU_SRLV;
               FN_SRAV: dec.alu_op = ALU_SRAV;
               FN_ADD:  dec.alu_op = ALU_ADD;
               FN_ADDU: dec.alu_op = ALU_ADDU;
               FN_SUB:  dec.alu_op = ALU_SUB;
               FN_SUBU: dec.alu_op = ALU_SUBU;
               FN_AND:  dec.alu_op = ALU_AND;
               FN_OR:   dec.alu_op = ALU_OR;
               FN_XOR:  dec.alu_op = ALU_XOR;
               FN_NOR:  dec.alu_op = ALU_NOR;
               FN_SLT:  dec.alu_op = ALU_SLT;
               FN_SLTU: dec.alu_op = ALU_SLTU;
               FN_SYSCALL: begin
                  dec        = '0;
                  dec.is_sys = 1'b1;
               end
               // unknown function becomes a bubble
               default: dec = '0;
            endcase
         end
         OP_ADDI:  dec.alu_op = ALU_ADD;
         OP_ADDIU: dec.alu_op = ALU_ADDU;
         OP_SLTI:  dec.alu_op = ALU_SLT;
         OP_SLTIU: dec.alu_op = ALU_SLTU;
         OP_ANDI:  dec.alu_op = ALU_AND;
         OP_ORI:   dec.alu_op = ALU_OR;
         OP_XORI:  dec.alu_op = ALU_XOR;
         OP_LUI:   dec.alu_op = ALU_LUI;
         // loads add the offset to rs
         OP_LB:    dec.load_op = LD_LB;
         OP_LBU:   dec.load_op = LD_LBU;
         OP_LH:    dec.load_op = LD_LH;
         OP_LHU:   dec.load_op = LD_LHU;
         OP_LW:    dec.load_op = LD_LW;
         OP_SB, OP_SH, OP_SW: begin
            dec.reg_we   = 1'b0;
            dec.store_op = (op == OP_SB) ? ST_SB : ((op == OP_SH) ? ST_SH : ST_SW);
         end
         default: dec = '0;
      endcase
   end

   // raw check against execute and memory, writeback is covered by the regfile
   assign hazard   = raw_hit(rs_idx, ex_ctrl) || raw_hit(rt_idx, ex_ctrl) ||
                     raw_hit(rs_idx, mem_ctrl) || raw_hit(rt_idx, mem_ctrl);
   assign stall    = inst_valid && hazard;
   assign sys_seen = inst_valid && (op == OP_SPECIAL) && (funct == FN_SYSCALL);

   always_comb begin
      id_ex.ctrl   = (stall || sys_issued || !inst_valid) ? '0 : dec;
      id_ex.rs_val = rs_val;
      id_ex.rt_val = rt_val;
      id_ex.imm    = zext ? {16'h0, imm16} : {{16{imm16[15]}}, imm16};
      id_ex.shamt  = inst_q[10:6];
   end

   // producer drains from ex to mem to wb, so two bubbles always clear it
   assert property (@(posedge clk) disable iff (!rst_b) stall [*2] |=> !stall);

endmodule

// ==== hw/mips_core.sv ====
// mips five-stage pipeline
module mips_core #(
   parameter mips_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic                 clk,
   input  logic                 rst_b,
   output mips_pkg::word_addr_t inst_addr,
   input  mips_pkg::word_t      inst,
   output mips_pkg::word_addr_t mem_addr,
   output mips_pkg::word_t      mem_data_in,
   input  mips_pkg::word_t      mem_data_out,
   output mips_pkg::byte_en_t   mem_write_en,
   output logic                 halted
);
   import mips_pkg::*;

   word_t    pc;
   logic     fetch_adv;
   logic     stall;
   logic     sys_seen;
   reg_idx_t rs_idx;
   reg_idx_t rt_idx;
   word_t    rs_val;
   word_t    rt_val;
   id_ex_t   id_ex;
   // stage registers
   id_ex_t   ex_q;
   ex_mem_t  mem_q;
   mem_wb_t  wb_q;
   // execute and memory results
   word_t    alu_b;
   word_t    alu_result;
   word_t    load_data;
   ex_mem_t  ex_mem_d;
   mem_wb_t  mem_wb_d;

   // fetch freezes on a hazard, on a syscall in decode and after halt
   assign fetch_adv = !stall && !sys_seen && !halted;
   assign inst_addr = pc[31:2];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc <= text_start;
      end else if (fetch_adv) begin
         pc <= pc + 32'd4;
      end
   end

   mips_decode i_mips_decode (
      .clk         (clk),
      .rst_b       (rst_b),
      .inst        (inst),
      .pc_plus4_en (fetch_adv),
      .rs_idx      (rs_idx),
      .rt_idx      (rt_idx),
      .rs_val      (rs_val),
      .rt_val      (rt_val),
      .ex_ctrl     (ex_q.ctrl),
      .mem_ctrl    (mem_q.ctrl),
      .id_ex       (id_ex),
      .stall       (stall),
      .sys_seen    (sys_seen)
   );

   // written from writeback, read in decode
   mips_regfile i_mips_regfile (
      .clk    (clk),
      .rst_b  (rst_b),
      .rs_idx (rs_idx),
      .rt_idx (rt_idx),
      .rs_val (rs_val),
      .rt_val (rt_val),
      .wb     (wb_q)
   );

   // execute
   assign alu_b = ex_q.ctrl.use_imm ? ex_q.imm : ex_q.rt_val;

   mips_alu i_mips_alu (
      .op     (ex_q.ctrl.alu_op),
      .a      (ex_q.rs_val),
      .b      (alu_b),
      .shamt  (ex_q.shamt),
      .result (alu_result)
   );

   always_comb begin
      ex_mem_d.ctrl       = ex_q.ctrl;
      ex_mem_d.alu_result = alu_result;
      ex_mem_d.store_val  = ex_q.rt_val;
   end

   // memory, ideal port answers in the same cycle
   assign mem_addr = mem_q.alu_result[31:2];

   mips_mem_align i_mips_mem_align (
      .ex_mem       (mem_q),
      .mem_data_out (mem_data_out),
      .mem_data_in  (mem_data_in),
      .mem_write_en (mem_write_en),
      .load_data    (load_data)
   );

   always_comb begin
      mem_wb_d.reg_we  = mem_q.ctrl.reg_we;
      mem_wb_d.wr_reg  = mem_q.ctrl.wr_reg;
      mem_wb_d.wr_data = (mem_q.ctrl.load_op != LD_NONE) ? load_data : mem_q.alu_result;
      mem_wb_d.is_sys  = mem_q.ctrl.is_sys;
   end

   // stage registers move every cycle, a stall shows up as a bubble from decode
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ex_q   <= '0;
         mem_q  <= '0;
         wb_q   <= '0;
         halted <= 1'b0;
      end else begin
         ex_q  <= id_ex;
         mem_q <= ex_mem_d;
         wb_q  <= mem_wb_d;
         // sticky once the syscall retires
         if (wb_q.is_sys) begin
            halted <= 1'b1;
         end
      end
   end

   // lane enables only for a store in the memory stage
   assert property (@(posedge clk) disable iff (!rst_b)
      (mem_q.ctrl.store_op == ST_NONE) |-> (mem_write_en == '0));

endmodule

// ==== tb/tb_mips_core.sv ====
// mips pipeline testbench
module tb_mips_core;
   import mips_pkg::*;

   // reset pc, kept off the core default on purpose
   localparam word_t text_base  = 32'h0040_1000;
   localparam word_t data_base  = 32'h1000_0000;
   localparam int    max_cycles = 3000;

   // one write seen on the data port
   typedef struct packed {
      word_addr_t addr;
      word_t      data;
      byte_en_t   strb;
   } store_t;

   logic        clk;
   logic        rst_b;
   word_addr_t  inst_addr;
   word_t       inst;
   word_addr_t  mem_addr;
   word_t       mem_data_in;
   word_t       mem_data_out;
   byte_en_t    mem_write_en;
   logic        halted;

   word_t       imem [256];
   word_t       dmem [256];
   logic [29:0] inst_off;
   // program under construction and its expected stores
   word_t       prog [$];
   store_t      exp_st [$];
   store_t      got_st [$];
   // register values as the program should leave them
   word_t       mregs [32];
   int          next_slot;
   int          cycle_count = 0;
   word_t       lcg_state   = 32'h27ce_0f1f;

   funct_e alu_fns [16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                            FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};

   mips_core #(.text_start(text_base)) i_mips_core (
      .clk          (clk),
      .rst_b        (rst_b),
      .inst_addr    (inst_addr),
      .inst         (inst),
      .mem_addr     (mem_addr),
      .mem_data_in  (mem_data_in),
      .mem_data_out (mem_data_out),
      .mem_write_en (mem_write_en),
      .halted       (halted)
   );

   // ideal memories, both answer in the same cycle
   assign inst_off     = inst_addr - text_base[31:2];
   assign inst         = imem[inst_off[7:0]];
   assign mem_data_out = dmem[mem_addr[7:0]];

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= max_cycles) begin
         abort_run("timeout: the core never halted before the cycle limit");
      end
   end

   // sample the store port mid cycle where it is stable
   always @(negedge clk) begin : capture_store
      store_t s;
      if (rst_b && (mem_write_en != '0)) begin
         s.addr = mem_addr;
         s.data = mem_data_in & lane_mask(mem_write_en);
         s.strb = mem_write_en;
         got_st.push_back(s);
         for (int b = 0; b < 4; b++) begin
            if (mem_write_en[b]) begin
               dmem[mem_addr[7:0]][8*b +: 8] = mem_data_in[8*b +: 8];
            end
         end
      end
   end

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at %0t", $time);
   endtask

   task automatic check_word(string sig, word_t exp, word_t act);
      if (exp !== act) begin
         abort_run($sformatf("mismatch time=%0t %s expected=%h actual=%h", $time, sig, exp, act));
      end
   endtask

   task automatic check_strobe(string sig, byte_en_t exp, byte_en_t act);
      if (exp !== act) begin
         abort_run($sformatf("mismatch time=%0t %s expected=%b actual=%b", $time, sig, exp, act));
      end
   endtask

   task automatic check_addr(string sig, word_addr_t exp, word_addr_t act);
      if (exp !== act) begin
         abort_run($sformatf("mismatch time=%0t %s expected=%h actual=%h", $time, sig, exp, act));
      end
   endtask

   // instruction encoders
   function automatic word_t enc_r(funct_e fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                   logic [4:0] sh);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t enc_i(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // base register sits in the rs field
   function automatic word_t enc_mem(opcode_e op, reg_idx_t base, reg_idx_t rt,
                                     logic [15:0] off);
      return enc_i(op, base, rt, off);
   endfunction

   function automatic word_t lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // preload pattern, every word differs
   function automatic word_t fill_word(int i);
      word_t x;
      x = 32'(i) * 32'h9e37_79b9 + 32'h6d2b_79f5;
      return x ^ (x >> 15);
   endfunction

   function automatic word_t lane_mask(byte_en_t s);
      return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
   endfunction

   // signed compare from the sign bits, then magnitude
   function automatic word_t less_signed(word_t a, word_t b);
      if (a[31] != b[31]) begin
         return {31'b0, a[31]};
      end
      return {31'b0, a < b};
   endfunction

   function automatic word_t shift_arith(word_t b, logic [4:0] s);
      word_t fill;
      fill = b[31] ? ~(32'hffff_ffff >> s) : 32'h0;
      return (b >> s) | fill;
   endfunction

   // reference for the special group, a is rs and b is rt
   function automatic word_t model_r(funct_e fn, word_t a, word_t b, logic [4:0] sh);
      case (fn)
         FN_ADD, FN_ADDU: return a + b;
         FN_SUB, FN_SUBU: return a - b;
         FN_AND:  return a & b;
         FN_OR:   return a | b;
         FN_XOR:  return a ^ b;
         FN_NOR:  return ~(a | b);
         FN_SLT:  return less_signed(a, b);
         FN_SLTU: return {31'b0, a < b};
         FN_SLL:  return b << sh;
         FN_SRL:  return b >> sh;
         FN_SRA:  return shift_arith(b, sh);
         FN_SLLV: return b << a[4:0];
         FN_SRLV: return b >> a[4:0];
         FN_SRAV: return shift_arith(b, a[4:0]);
         default: return 32'h0;
      endcase
   endfunction

   // logic immediates zero extend, arithmetic and compares sign extend
   function automatic word_t model_i(opcode_e op, word_t a, logic [15:0] imm);
      word_t se;
      word_t ze;
      se = {{16{imm[15]}}, imm};
      ze = {16'h0, imm};
      case (op)
         OP_ADDI, OP_ADDIU: return a + se;
         OP_SLTI:  return less_signed(a, se);
         OP_SLTIU: return {31'b0, a < se};
         OP_ANDI:  return a & ze;
         OP_ORI:   return a | ze;
         OP_XORI:  return a ^ ze;
         OP_LUI:   return {imm, 16'h0};
         default:  return 32'h0;
      endcase
   endfunction

   function automatic word_t model_load(opcode_e op, word_t w, logic [1:0] k);
      logic [7:0]  b;
      logic [15:0] h;
      case (k)
         2'd0:    b = w[7:0];
         2'd1:    b = w[15:8];
         2'd2:    b = w[23:16];
         default: b = w[31:24];
      endcase
      h = k[1] ? w[31:16] : w[15:0];
      case (op)
         OP_LB:   return {{24{b[7]}}, b};
         OP_LBU:  return {24'h0, b};
         OP_LH:   return {{16{h[15]}}, h};
         OP_LHU:  return {16'h0, h};
         default: return w;
      endcase
   endfunction

   // program builders keep mregs in step with each instruction
   task automatic begin_program();
      prog.delete();
      exp_st.delete();
      next_slot = 0;
      foreach (mregs[i]) begin
         mregs[i] = 32'h0;
      end
   endtask

   task automatic put_r(funct_e fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, logic [4:0] sh);
      prog.push_back(enc_r(fn, rs, rt, rd, sh));
      if (rd != '0) begin
         mregs[rd] = model_r(fn, mregs[rs], mregs[rt], sh);
      end
   endtask

   task automatic put_i(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
      prog.push_back(enc_i(op, rs, rt, imm));
      if (rt != '0) begin
         mregs[rt] = model_i(op, mregs[rs], imm);
      end
   endtask

   task automatic put_li(reg_idx_t rd, word_t v);
      put_i(OP_LUI, 0, rd, v[31:16]);
      put_i(OP_ORI, rd, rd, v[15:0]);
   endtask

   // r1 holds the data base for every access
   task automatic put_base();
      put_i(OP_LUI, 0, 1, data_base[31:16]);
   endtask

   task automatic put_syscall();
      prog.push_back(enc_r(FN_SYSCALL, 0, 0, 0, 0));
   endtask

   // each store gets a fresh word slot, k is the byte offset in it
   task automatic store_next(opcode_e op, reg_idx_t rt, int k);
      logic [15:0] off;
      word_t       ea;
      word_t       v;
      byte_en_t    s;
      store_t      e;
      off = 16'(next_slot * 4 + k);
      next_slot++;
      ea = mregs[1] + {{16{off[15]}}, off};
      v  = mregs[rt];
      case (op)
         OP_SB: begin
            // only the addressed lane is enabled
            s            = 4'b0000;
            s[ea[1:0]]   = 1'b1;
            e.data       = {4{v[7:0]}};
         end
         OP_SH: begin
            s      = ea[1] ? 4'b1100 : 4'b0011;
            e.data = {2{v[15:0]}};
         end
         default: begin
            s      = 4'b1111;
            e.data = v;
         end
      endcase
      e.addr = ea[31:2];
      e.strb = s;
      e.data = e.data & lane_mask(s);
      exp_st.push_back(e);
      prog.push_back(enc_mem(op, 1, rt, off));
   endtask

   // loads read the untouched preload area from word 200 up
   task automatic put_load(opcode_e op, reg_idx_t rt, int wsel, int k);
      logic [15:0] off;
      word_t       ea;
      off = 16'(800 + wsel * 4 + k);
      ea  = mregs[1] + {{16{off[15]}}, off};
      prog.push_back(enc_mem(op, 1, rt, off));
      if (rt != '0) begin
         mregs[rt] = model_load(op, fill_word(int'(ea[9:2])), ea[1:0]);
      end
   endtask

   task automatic load_memories();
      for (int i = 0; i < 256; i++) begin
         if (i < prog.size()) begin
            imem[i] = prog[i];
         end else begin
            imem[i] = 32'h0;
         end
         dmem[i] = fill_word(i);
      end
   endtask

   task automatic check_reset_outputs();
      check_addr("inst_addr", text_base[31:2], inst_addr);
      check_strobe("mem_write_en", 4'b0000, mem_write_en);
      check_word("halted", 32'h0, {31'b0, halted});
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst_b = 1'b0;
      got_st.delete();
      repeat (4) begin
         @(posedge clk);
         #1;
         check_reset_outputs();
      end
      rst_b = 1'b1;
      check_reset_outputs();
   endtask

   task automatic wait_halted();
      do begin
         @(posedge clk);
         #1;
      end while (halted !== 1'b1);
   endtask

   task automatic check_stores();
      check_word("store_count", 32'(exp_st.size()), 32'(got_st.size()));
      foreach (exp_st[i]) begin
         check_addr($sformatf("mem_addr[store %0d]", i), exp_st[i].addr, got_st[i].addr);
         check_word($sformatf("mem_data_in[store %0d]", i), exp_st[i].data, got_st[i].data);
         check_strobe($sformatf("mem_write_en[store %0d]", i), exp_st[i].strb, got_st[i].strb);
      end
   endtask

   task automatic run_program();
      int stores_at_halt;
      load_memories();
      apply_reset();
      wait_halted();
      // nothing may reach the store port once halted is up
      stores_at_halt = got_st.size();
      repeat (3) begin
         @(posedge clk);
         #1;
      end
      if (got_st.size() != stores_at_halt) begin
         abort_run("a store reached the data port after halted rose");
      end
      check_stores();
   endtask

   task automatic test_reset_and_syscall();
      word_addr_t frozen;
      begin_program();
      put_syscall();
      run_program();
      // fetch stops with the syscall in decode, one word past it
      frozen = inst_addr;
      check_addr("inst_addr", text_base[31:2] + 30'd1, frozen);
      repeat (6) begin
         @(posedge clk);
         #1;
         check_addr("inst_addr", frozen, inst_addr);
         check_strobe("mem_write_en", 4'b0000, mem_write_en);
         check_word("halted", 32'h1, {31'b0, halted});
      end
   endtask

   task automatic test_alu_chains();
      begin_program();
      put_base();
      put_li(2, 32'h1234_5678);
      put_li(3, 32'h8765_4321);
      put_r(FN_ADD, 2, 3, 4, 0);
      store_next(OP_SW, 4, 0);
      put_r(FN_ADDU, 4, 2, 5, 0);
      put_r(FN_SUB, 5, 3, 6, 0);
      put_r(FN_SUBU, 3, 6, 7, 0);
      store_next(OP_SW, 7, 0);
      put_i(OP_ADDI, 7, 8, 16'hfffb);
      put_i(OP_ADDIU, 8, 9, 16'h7fff);
      store_next(OP_SW, 9, 0);
      put_r(FN_AND, 2, 3, 10, 0);
      put_r(FN_OR, 10, 3, 11, 0);
      put_r(FN_XOR, 11, 2, 12, 0);
      put_r(FN_NOR, 12, 3, 13, 0);
      store_next(OP_SW, 13, 0);
      put_i(OP_ANDI, 13, 14, 16'hf0f0);
      put_i(OP_ORI, 14, 15, 16'h8001);
      put_i(OP_XORI, 15, 16, 16'hffff);
      store_next(OP_SW, 16, 0);
      // negative against positive, signed and unsigned disagree
      put_r(FN_SLT, 3, 2, 17, 0);
      put_r(FN_SLTU, 3, 2, 18, 0);
      store_next(OP_SW, 17, 0);
      store_next(OP_SW, 18, 0);
      put_i(OP_SLTI, 3, 19, 16'hffff);
      put_i(OP_SLTIU, 2, 20, 16'hffff);
      store_next(OP_SW, 19, 0);
      store_next(OP_SW, 20, 0);
      // r21 is in writeback when subu reads it
      put_r(FN_ADDU, 2, 3, 21, 0);
      put_i(OP_ORI, 0, 22, 16'h0055);
      put_i(OP_ORI, 0, 23, 16'h00aa);
      put_r(FN_SUBU, 21, 22, 24, 0);
      store_next(OP_SW, 24, 0);
      put_syscall();
      run_program();
   endtask

   task automatic test_shifts();
      logic [4:0] amts [5];
      word_t      vamts [4];
      amts  = '{5'd0, 5'd1, 5'd4, 5'd16, 5'd31};
      // only the low five bits of rs count
      vamts = '{32'd0, 32'd7, 32'd31, 32'hffff_ffe9};
      begin_program();
      put_base();
      put_li(2, 32'h8000_00f1);
      put_li(3, 32'h7ff0_0e01);
      foreach (amts[i]) begin
         put_r(FN_SLL, 0, 2, 4, amts[i]);
         store_next(OP_SW, 4, 0);
         put_r(FN_SRL, 0, 2, 4, amts[i]);
         store_next(OP_SW, 4, 0);
         put_r(FN_SRA, 0, 2, 4, amts[i]);
         store_next(OP_SW, 4, 0);
         put_r(FN_SRA, 0, 3, 4, amts[i]);
         store_next(OP_SW, 4, 0);
      end
      foreach (vamts[i]) begin
         put_li(5, vamts[i]);
         put_r(FN_SLLV, 5, 2, 6, 0);
         store_next(OP_SW, 6, 0);
         put_r(FN_SRLV, 5, 2, 6, 0);
         store_next(OP_SW, 6, 0);
         put_r(FN_SRAV, 5, 2, 6, 0);
         store_next(OP_SW, 6, 0);
         put_r(FN_SRAV, 5, 3, 6, 0);
         store_next(OP_SW, 6, 0);
      end
      put_syscall();
      run_program();
   endtask

   task automatic test_sub_word();
      begin_program();
      put_base();
      put_li(2, 32'hcafe_b0a5);
      for (int k = 0; k < 4; k++) begin
         store_next(OP_SB, 2, k);
      end
      store_next(OP_SH, 2, 0);
      store_next(OP_SH, 2, 2);
      // every extension form at every legal offset of two words
      for (int w = 0; w < 2; w++) begin
         for (int k = 0; k < 4; k++) begin
            put_load(OP_LB, 4, w, k);
            store_next(OP_SW, 4, 0);
            put_load(OP_LBU, 4, w, k);
            store_next(OP_SW, 4, 0);
         end
         for (int k = 0; k < 4; k += 2) begin
            put_load(OP_LH, 4, w, k);
            store_next(OP_SW, 4, 0);
            put_load(OP_LHU, 4, w, k);
            store_next(OP_SW, 4, 0);
         end
      end
      put_syscall();
      run_program();
   endtask

   task automatic test_random_ops();
      word_t ra;
      word_t rb;
      word_t sel;
      begin_program();
      put_base();
      repeat (12) begin
         ra  = lcg_next();
         rb  = lcg_next();
         sel = lcg_next();
         put_li(2, ra);
         put_li(3, rb);
         put_r(alu_fns[sel[27:24]], 2, 3, 4, sel[10:6]);
         store_next(OP_SW, 4, 0);
      end
      // stores packed right up against the syscall
      put_r(FN_XOR, 2, 3, 5, 0);
      store_next(OP_SW, 5, 0);
      store_next(OP_SH, 5, 2);
      store_next(OP_SB, 5, 3);
      put_syscall();
      run_program();
   endtask

   initial begin
      rst_b = 1'b0;
      for (int i = 0; i < 256; i++) begin
         imem[i] = 32'h0;
         dmem[i] = fill_word(i);
      end
      test_reset_and_syscall();
      test_alu_chains();
      test_shifts();
      test_sub_word();
      test_random_ops();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== mips_core.f ====
hw/mips_pkg.sv
hw/mips_regfile.sv
hw/mips_alu.sv
hw/mips_mem_align.sv
hw/mips_decode.sv
hw/mips_core.sv
tb/tb_mips_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LOG       ?= sim.log

TOP      := tb_mips_core
FILELIST := mips_core.f
SRCS     := $(shell grep -v '^+' $(FILELIST))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
